// ==== softermax.f ====
+incdir+verilog
verilog/smx_arith_pkg.sv
verilog/smx_stream_pkg.sv
verilog/softermax_chunk_buffer.sv
verilog/softermax_renorm.sv
verilog/softermax_divide.sv
verilog/softermax_global_norm.sv
dv/softermax_tb.sv

// ==== Makefile ====
# Verilator build and run for the softermax global normalization testbench

TOP = softermax_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns -f softermax.f --top-module $(TOP)

# Fails unless the pass message shows up in the simulation output
run: compile
	./obj_dir/V$(TOP) | awk '{ print } /^NO ERRORS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== dv/softermax_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softermax global normalization testbench
// Random and directed vectors against a queue-based reference model,
// checked by concurrent assertions on the output stream
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "smx_defines.svh"

module softermax_tb;

    localparam int CLK_PERIOD = 100;
    localparam int P          = `SMX_PARALLELISM;
    localparam int N_EQUAL    = 3;
    localparam int N_DIFF     = 4;
    localparam int N_WIDE     = 3;
    localparam int N_B2B      = 6;
    localparam int N_STALL    = 6;
    localparam int N_VECS     = N_EQUAL + N_DIFF + N_WIDE + N_B2B + N_STALL;
    // Worst case of 40 cycles per element, plus reset and drain
    localparam int WATCHDOG_CYCLES = N_VECS * `SMX_TOTAL_DIM * 40 + 1000;

    logic                          clk = 1'b0;
    logic                          rst_n;
    smx_stream_pkg::in_beat_t      in_beat;
    logic                          in_valid;
    logic                          in_ready;
    smx_arith_pkg::prob_t          out_data;
    logic                          out_last;
    logic                          out_valid;
    logic                          out_ready;

    // Expected results, last flag on top of the probability
    logic [`SMX_OUT_WIDTH:0]       exp_q [$];
    logic [`SMX_OUT_WIDTH:0]       exp_head;
    logic                          exp_pending;
    smx_stream_pkg::in_beat_t      cur_vec [`SMX_DEPTH];
    int                            exp_total;
    int                            out_cnt;
    logic                          stall_mode;
    string                         test_name;
    int                            errs_at_start;
    int                            outs_at_start;
    int                            tests_run;
    int                            tests_failed;
    int                            fail_data;
    int                            fail_last;
    int                            fail_extra;
    int                            fail_hold;
    int                            fail_reset;

    softermax_global_norm UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Pops one result per output transfer and exposes the next one
    always @(posedge clk) begin : scoreboard
        if (rst_n && out_valid && out_ready) begin
            out_cnt <= out_cnt + 1;
            if (exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
        end
        if (exp_q.size() > 0) begin
            exp_head    <= exp_q[0];
            exp_pending <= 1'b1;
        end else begin
            exp_pending <= 1'b0;
        end
    end

    initial begin : ready_gen
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            out_ready <= stall_mode ? ($urandom_range(3, 0) != 0) : 1'b1;
        end
    end

    a_reset_state: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid && in_ready)
        else begin
            $display("DUT not idle after reset, out_valid %0b in_ready %0b",
                     $sampled(out_valid), $sampled(in_ready));
            fail_reset++;
        end

    a_expected: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> exp_pending)
        else begin
            $display("Output beat arrived with no result pending in test %s", test_name);
            fail_extra++;
        end

    a_data: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready && exp_pending |-> out_data == exp_head[`SMX_OUT_WIDTH-1:0])
        else begin
            $display("FAILED %s: out_data expected %0d, actual %0d", test_name,
                     $sampled(exp_head[`SMX_OUT_WIDTH-1:0]), $sampled(out_data));
            fail_data++;
        end

    a_last: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready && exp_pending |-> out_last == exp_head[`SMX_OUT_WIDTH])
        else begin
            $display("FAILED %s: out_last expected %0b, actual %0b", test_name,
                     $sampled(exp_head[`SMX_OUT_WIDTH]), $sampled(out_last));
            fail_last++;
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else begin
            $display("Output changed or dropped while stalled in test %s", test_name);
            fail_hold++;
        end

    function automatic int total_errors();
        return fail_data + fail_last + fail_extra + fail_hold + fail_reset;
    endfunction

    // Random maxima in [max_lo, max_hi], power-of-two values or zero
    task automatic fill_vector(input int max_lo, input int max_hi, input int zero_pct);
        for (int b = 0; b < `SMX_DEPTH; b++) begin
            cur_vec[b].local_max =
                smx_arith_pkg::exp_t'(max_lo + int'($urandom_range(max_hi - max_lo, 0)));
            for (int l = 0; l < P; l++) begin
                if (int'($urandom_range(99, 0)) < zero_pct) begin
                    cur_vec[b].values[l] = '0;
                end else begin
                    cur_vec[b].values[l] = smx_arith_pkg::value_t'(1) << $urandom_range(7, 0);
                end
            end
        end
    endtask

    task automatic set_maxima(input int m0, input int m1, input int m2, input int m3);
        cur_vec[0].local_max = smx_arith_pkg::exp_t'(m0);
        cur_vec[1].local_max = smx_arith_pkg::exp_t'(m1);
        cur_vec[2].local_max = smx_arith_pkg::exp_t'(m2);
        cur_vec[3].local_max = smx_arith_pkg::exp_t'(m3);
    endtask

    // Shift by the gap to the signed global max, then floor(v * 128 / sum)
    task automatic model_vector();
        int gmax;
        int lmax;
        int gap;
        int sum;
        int idx;
        int prob;
        int scaled [`SMX_TOTAL_DIM];
        gmax = int'($signed(cur_vec[0].local_max));
        for (int b = 1; b < `SMX_DEPTH; b++) begin
            lmax = int'($signed(cur_vec[b].local_max));
            if (lmax > gmax) begin
                gmax = lmax;
            end
        end
        sum = 0;
        for (int b = 0; b < `SMX_DEPTH; b++) begin
            gap = gmax - int'($signed(cur_vec[b].local_max));
            for (int l = 0; l < P; l++) begin
                idx = b * P + l;
                scaled[idx] = (gap >= `SMX_VALUE_WIDTH) ? 0 : int'(cur_vec[b].values[l]) >> gap;
                sum = sum + scaled[idx];
            end
        end
        for (int i = 0; i < `SMX_TOTAL_DIM; i++) begin
            prob = (sum == 0) ? 0 : (scaled[i] * (1 << `SMX_OUT_FRAC)) / sum;
            exp_q.push_back({(i == `SMX_TOTAL_DIM - 1), smx_arith_pkg::prob_t'(prob)});
        end
        exp_total = exp_total + `SMX_TOTAL_DIM;
    endtask

    // Called just after a rising edge, returns at the edge of the transfer
    task automatic send_beat(input smx_stream_pkg::in_beat_t b, input int max_gap);
        int gap;
        gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
        if (gap > 0) begin
            in_valid <= 1'b0;
            repeat (gap) @(posedge clk);
        end
        in_beat  <= b;
        in_valid <= 1'b1;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
    endtask

    task automatic run_vector(input int max_gap);
        model_vector();
        for (int b = 0; b < `SMX_DEPTH; b++) begin
            send_beat(cur_vec[b], max_gap);
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errs_at_start = total_errors();
        outs_at_start = out_cnt;
    endtask

    task automatic finish_test();
        int errs;
        in_valid <= 1'b0;
        while (out_cnt < exp_total) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        errs = total_errors() - errs_at_start;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: passed, %0d outputs checked", test_name, out_cnt - outs_at_start);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d errors", test_name, errs);
        end
    endtask

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, %0d of %0d results received in test %s",
                 WATCHDOG_CYCLES, out_cnt, exp_total, test_name);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : main
        void'($urandom(32'hbebc9865));
        rst_n      = 1'b0;
        in_beat    = '0;
        in_valid   = 1'b0;
        stall_mode = 1'b0;
        exp_total  = 0;
        out_cnt    = 0;
        tests_run  = 0;
        tests_failed = 0;
        fail_data  = 0;
        fail_last  = 0;
        fail_extra = 0;
        fail_hold  = 0;
        fail_reset = 0;
        start_test("reset");
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        finish_test();

        start_test("equal_max");
        for (int n = 0; n < N_EQUAL; n++) begin
            fill_vector(-20, 20, 10);
            set_maxima(cur_vec[0].local_max, cur_vec[0].local_max,
                       cur_vec[0].local_max, cur_vec[0].local_max);
            run_vector(0);
        end
        finish_test();

        // Maxima straddle zero so the signed compare matters
        start_test("diff_max");
        for (int n = 0; n < N_DIFF; n++) begin
            fill_vector(-4, 3, 10);
            run_vector(0);
        end
        finish_test();

        start_test("wide_gap");
        fill_vector(0, 0, 0);
        set_maxima(9, 2, 1, -128);
        run_vector(0);
        fill_vector(0, 0, 0);
        set_maxima(127, -128, 119, 120);
        run_vector(0);
        fill_vector(-5, 5, 100);
        run_vector(0);
        finish_test();

        start_test("back_to_back");
        for (int n = 0; n < N_B2B; n++) begin
            fill_vector(-12, 12, 20);
            run_vector(0);
        end
        finish_test();

        start_test("backpressure");
        stall_mode = 1'b1;
        for (int n = 0; n < N_STALL; n++) begin
            fill_vector(-10, 10, 20);
            run_vector(3);
        end
        finish_test();

        $display("summary: %0d tests, %0d failed, %0d outputs checked, %0d errors",
                 tests_run, tests_failed, out_cnt, total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/softermax_global_norm.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softermax global normalization
// Chunk buffering with max search, renormalize and sum, then divide
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module softermax_global_norm (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire smx_stream_pkg::in_beat_t      in_beat,
    input  wire logic                          in_valid,
    output logic                               in_ready,
    output smx_arith_pkg::prob_t               out_data,
    output logic                               out_last,
    output logic                               out_valid,
    input  wire logic                          out_ready
);

    smx_stream_pkg::chunk_beat_t  chunk;
    logic                         chunk_valid;
    logic                         chunk_ready;
    smx_stream_pkg::norm_beat_t   norm;
    logic                         norm_valid;
    logic                         norm_ready;

    softermax_chunk_buffer u_chunk_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_beat     (in_beat),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .chunk       (chunk),
        .chunk_valid (chunk_valid),
        .chunk_ready (chunk_ready)
    );

    softermax_renorm u_renorm (
        .clk         (clk),
        .rst_n       (rst_n),
        .chunk       (chunk),
        .chunk_valid (chunk_valid),
        .chunk_ready (chunk_ready),
        .norm        (norm),
        .norm_valid  (norm_valid),
        .norm_ready  (norm_ready)
    );

    softermax_divide u_divide (
        .clk         (clk),
        .rst_n       (rst_n),
        .norm        (norm),
        .norm_valid  (norm_valid),
        .norm_ready  (norm_ready),
        .out_data    (out_data),
        .out_last    (out_last),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

`default_nettype wire

// ==== verilog/softermax_divide.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softermax bit-serial divider
// Restoring division of each rescaled lane by the vector sum, one quotient
// bit per cycle, emitting one probability per output beat
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "smx_defines.svh"

module softermax_divide (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire smx_stream_pkg::norm_beat_t    norm,
    input  wire logic                          norm_valid,
    output logic                               norm_ready,
    output smx_arith_pkg::prob_t               out_data,
    output logic                               out_last,
    output logic                               out_valid,
    input  wire logic                          out_ready
);

    localparam int P      = `SMX_PARALLELISM;
    localparam int LANE_W = $clog2(P);
    localparam int ITER_W = $clog2(`SMX_OUT_WIDTH);
    localparam int DIV_W  = `SMX_VALUE_WIDTH + `SMX_OUT_FRAC;
    localparam logic [LANE_W-1:0] LANE_LAST = LANE_W'(P - 1);
    localparam logic [ITER_W-1:0] ITER_LAST = ITER_W'(`SMX_OUT_WIDTH - 1);

    smx_stream_pkg::div_state_t  state;
    smx_stream_pkg::norm_beat_t  beat_q;
    logic [LANE_W-1:0]           lane;
    logic [ITER_W-1:0]           iter;
    logic [DIV_W-1:0]            dividend;
    smx_arith_pkg::sum_t         rem;
    logic [`SMX_SUM_WIDTH:0]     trial;
    smx_arith_pkg::sum_t         diff;
    logic [`SMX_OUT_WIDTH-1:0]   shreg;
    smx_arith_pkg::prob_t        quot;
    logic                        bit_set;
    logic                        norm_fire;

    assign norm_ready = (state == smx_stream_pkg::IDLE);
    assign norm_fire  = norm_valid && norm_ready;

    // value * 2^OUT_FRAC, upper bits seed the remainder
    assign dividend = {beat_q.values[lane], {`SMX_OUT_FRAC{1'b0}}};
    assign trial    = {rem, shreg[`SMX_OUT_WIDTH-1]};
    assign diff     = trial[`SMX_SUM_WIDTH-1:0] - beat_q.sum;
    // Zero sum never sets a quotient bit
    assign bit_set  = (beat_q.sum != '0) && (trial >= {1'b0, beat_q.sum});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= smx_stream_pkg::IDLE;
            lane  <= '0;
            iter  <= '0;
        end else begin
            case (state)
                smx_stream_pkg::IDLE: begin
                    if (norm_fire) begin
                        state <= smx_stream_pkg::LOAD;
                        lane  <= '0;
                    end
                end
                smx_stream_pkg::LOAD: begin
                    state <= smx_stream_pkg::ITER;
                    iter  <= '0;
                end
                smx_stream_pkg::ITER: begin
                    iter <= iter + 1'b1;
                    if (iter == ITER_LAST) begin
                        state <= smx_stream_pkg::HOLD;
                    end
                end
                smx_stream_pkg::HOLD: begin
                    if (out_ready) begin
                        if (lane == LANE_LAST) begin
                            state <= smx_stream_pkg::IDLE;
                        end else begin
                            lane  <= lane + 1'b1;
                            state <= smx_stream_pkg::LOAD;
                        end
                    end
                end
                default: state <= smx_stream_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (norm_fire) begin
            beat_q <= norm;
        end
        if (state == smx_stream_pkg::LOAD) begin
            rem   <= smx_arith_pkg::sum_t'(dividend[DIV_W-1:`SMX_OUT_WIDTH]);
            shreg <= dividend[`SMX_OUT_WIDTH-1:0];
            quot  <= '0;
        end else if (state == smx_stream_pkg::ITER) begin
            // Restore by keeping the trial when the subtraction would go negative
            rem   <= bit_set ? diff : trial[`SMX_SUM_WIDTH-1:0];
            shreg <= {shreg[`SMX_OUT_WIDTH-2:0], 1'b0};
            quot  <= {quot[`SMX_OUT_WIDTH-2:0], bit_set};
        end
    end

    assign out_valid = (state == smx_stream_pkg::HOLD);
    assign out_data  = quot;
    assign out_last  = beat_q.last && (lane == LANE_LAST);

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last));

    // Each value is part of its own sum, so the ratio is at most one
    a_quot_bound: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_data <= smx_arith_pkg::prob_t'(1 << `SMX_OUT_FRAC));

endmodule

`default_nettype wire

// ==== verilog/softermax_renorm.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softermax renormalization
// Shifts each chunk down by its exponent gap to the global max, keeps the
// rescaled vector and its sum, then replays it with the sum attached
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "smx_defines.svh"

module softermax_renorm (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire smx_stream_pkg::chunk_beat_t   chunk,
    input  wire logic                          chunk_valid,
    output logic                               chunk_ready,
    output smx_stream_pkg::norm_beat_t         norm,
    output logic                               norm_valid,
    input  wire logic                          norm_ready
);

    localparam int P     = `SMX_PARALLELISM;
    localparam int CNT_W = $clog2(`SMX_DEPTH);
    localparam int SH_W  = $clog2(`SMX_VALUE_WIDTH);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`SMX_DEPTH - 1);

    smx_arith_pkg::gap_t            gap;
    smx_arith_pkg::value_t [P-1:0]  rescaled;
    smx_arith_pkg::sum_t            chunk_sum;
    smx_arith_pkg::value_t [P-1:0]  vec_mem [`SMX_DEPTH];
    smx_arith_pkg::sum_t            sum_q;
    logic [CNT_W-1:0]               wr_cnt;
    logic [CNT_W-1:0]               rd_cnt;
    logic                           replay;
    logic                           chunk_fire;
    logic                           norm_fire;

    assign chunk_ready = !replay;
    assign norm_valid  = replay;
    assign chunk_fire  = chunk_valid && chunk_ready;
    assign norm_fire   = norm_valid && norm_ready;

    always_comb begin
        // Sign-extended difference, never negative for a well-formed chunk
        gap = {chunk.global_max[`SMX_MAX_WIDTH-1], chunk.global_max}
            - {chunk.local_max[`SMX_MAX_WIDTH-1], chunk.local_max};
        chunk_sum = '0;
        for (int i = 0; i < P; i++) begin
            // Gap of a full value width or more shifts everything out
            if (gap >= `SMX_VALUE_WIDTH) begin
                rescaled[i] = '0;
            end else begin
                rescaled[i] = chunk.values[i] >> gap[SH_W-1:0];
            end
            chunk_sum = chunk_sum + smx_arith_pkg::sum_t'(rescaled[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_cnt <= '0;
            rd_cnt <= '0;
            replay <= 1'b0;
        end else begin
            if (chunk_fire) begin
                wr_cnt <= chunk.last ? '0 : wr_cnt + 1'b1;
                if (chunk.last) begin
                    replay <= 1'b1;
                    rd_cnt <= '0;
                end
            end
            if (norm_fire) begin
                rd_cnt <= (rd_cnt == LAST) ? '0 : rd_cnt + 1'b1;
                if (rd_cnt == LAST) begin
                    replay <= 1'b0;
                end
            end
        end
    end

    // First chunk of a vector restarts the sum
    always_ff @(posedge clk) begin
        if (chunk_fire) begin
            vec_mem[wr_cnt] <= rescaled;
            sum_q           <= (wr_cnt == '0) ? chunk_sum : sum_q + chunk_sum;
        end
    end

    assign norm = '{
        values: vec_mem[rd_cnt],
        sum:    sum_q,
        last:   (rd_cnt == LAST)
    };

    for (genvar i = 0; i < P; i++) begin : g_lane_chk
        a_rescale_bound: assert property (@(posedge clk) disable iff (!rst_n)
            chunk_fire |=> vec_mem[$past(wr_cnt)][i] <= $past(chunk.values[i]));
    end

endmodule

`default_nettype wire

// ==== verilog/softermax_chunk_buffer.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softermax chunk buffer
// Collects one vector of chunks while tracking the signed global max,
// then replays the chunks in order with that max attached
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "smx_defines.svh"

module softermax_chunk_buffer (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire smx_stream_pkg::in_beat_t      in_beat,
    input  wire logic                          in_valid,
    output logic                               in_ready,
    output smx_stream_pkg::chunk_beat_t        chunk,
    output logic                               chunk_valid,
    input  wire logic                          chunk_ready
);

    localparam int CNT_W = $clog2(`SMX_DEPTH);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`SMX_DEPTH - 1);

    smx_stream_pkg::buf_state_t  state;
    smx_stream_pkg::in_beat_t    beat_mem [`SMX_DEPTH];
    smx_arith_pkg::exp_t         run_max;
    smx_arith_pkg::exp_t         next_max;
    logic [CNT_W-1:0]            fill_cnt;
    logic [CNT_W-1:0]            rd_cnt;
    logic                        in_fire;
    logic                        chunk_fire;

    assign in_ready    = (state == smx_stream_pkg::FILL);
    assign chunk_valid = (state == smx_stream_pkg::REPLAY);
    assign in_fire     = in_valid && in_ready;
    assign chunk_fire  = chunk_valid && chunk_ready;

    // First beat of a vector seeds the running max
    always_comb begin
        if (fill_cnt == '0 || $signed(in_beat.local_max) > $signed(run_max)) begin
            next_max = in_beat.local_max;
        end else begin
            next_max = run_max;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= smx_stream_pkg::FILL;
            fill_cnt <= '0;
            rd_cnt   <= '0;
        end else begin
            case (state)
                smx_stream_pkg::FILL: begin
                    if (in_fire) begin
                        fill_cnt <= (fill_cnt == LAST) ? '0 : fill_cnt + 1'b1;
                        if (fill_cnt == LAST) begin
                            state  <= smx_stream_pkg::REPLAY;
                            rd_cnt <= '0;
                        end
                    end
                end
                smx_stream_pkg::REPLAY: begin
                    if (chunk_fire) begin
                        rd_cnt <= (rd_cnt == LAST) ? '0 : rd_cnt + 1'b1;
                        if (rd_cnt == LAST) begin
                            state <= smx_stream_pkg::FILL;
                        end
                    end
                end
                default: state <= smx_stream_pkg::FILL;
            endcase
        end
    end

    // Storage and running max, held still during replay
    always_ff @(posedge clk) begin
        if (in_fire) begin
            beat_mem[fill_cnt] <= in_beat;
            run_max            <= next_max;
        end
    end

    assign chunk = '{
        local_max:  beat_mem[rd_cnt].local_max,
        global_max: run_max,
        values:     beat_mem[rd_cnt].values,
        last:       (rd_cnt == LAST)
    };

    // Global max stays the same across all four replayed chunks
    a_gmax_steady: assert property (@(posedge clk) disable iff (!rst_n)
        chunk_fire && !chunk.last |=> chunk_valid && $stable(chunk.global_max));

    // No local max of the vector lies above the global max
    a_replay_max: assert property (@(posedge clk) disable iff (!rst_n)
        chunk_valid |-> $signed(chunk.global_max) >= $signed(chunk.local_max));

endmodule

`default_nettype wire

// ==== verilog/smx_stream_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softermax stream beat formats
// Payloads of the valid/ready links and the stage state machines
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "smx_defines.svh"

package smx_stream_pkg;

    // Input beat, values already scaled to their own local max
    typedef struct packed {
        smx_arith_pkg::exp_t                           local_max;
        smx_arith_pkg::value_t [`SMX_PARALLELISM-1:0]  values;
    } in_beat_t;

    // Replayed chunk with the global max attached
    typedef struct packed {
        smx_arith_pkg::exp_t                           local_max;
        smx_arith_pkg::exp_t                           global_max;
        smx_arith_pkg::value_t [`SMX_PARALLELISM-1:0]  values;
        logic                                          last;
    } chunk_beat_t;

    // Rescaled beat carrying the complete vector sum
    typedef struct packed {
        smx_arith_pkg::value_t [`SMX_PARALLELISM-1:0]  values;
        smx_arith_pkg::sum_t                           sum;
        logic                                          last;
    } norm_beat_t;

    typedef enum logic {FILL, REPLAY} buf_state_t;

    typedef enum logic [1:0] {IDLE, LOAD, ITER, HOLD} div_state_t;

endpackage

`default_nettype wire

// ==== verilog/smx_arith_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softermax arithmetic types
// Named widths for values, exponents, shift gaps, sums and probabilities
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "smx_defines.svh"

package smx_arith_pkg;

    // One lane value, unsigned fixed point
    typedef logic [`SMX_VALUE_WIDTH-1:0] value_t;

    // Local or global max exponent
    typedef logic signed [`SMX_MAX_WIDTH-1:0] exp_t;

    // Difference of two exponents, one bit wider
    typedef logic signed [`SMX_MAX_WIDTH:0] gap_t;

    typedef logic [`SMX_SUM_WIDTH-1:0] sum_t;

    // Normalized probability
    typedef logic [`SMX_OUT_WIDTH-1:0] prob_t;

endpackage

`default_nettype wire

// ==== verilog/smx_defines.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softermax global normalization shared constants
// Vector shape and the fixed-point widths of every stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef SMX_DEFINES_SVH
`define SMX_DEFINES_SVH

// Vector shape
`define SMX_TOTAL_DIM    16
`define SMX_PARALLELISM  4
`define SMX_DEPTH        (`SMX_TOTAL_DIM / `SMX_PARALLELISM)

// Power-of-two input values, unsigned Q4.4
`define SMX_VALUE_WIDTH  8
`define SMX_VALUE_FRAC   4

// Signed integer exponent of a local max
`define SMX_MAX_WIDTH    8

// Sum of 16 values needs 4 extra integer bits
`define SMX_SUM_WIDTH    12

// Output probability, Q1.7
`define SMX_OUT_WIDTH    8
`define SMX_OUT_FRAC     7

`endif
